// ==== Makefile ====
TOP = tbEncoderController

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only -Wall -f filelist.f --top-module encoderController

clean:
	rm -rf obj_dir

// ==== filelist.f ====
src/encoderSeqPkg.sv
src/frameGate.sv
src/subframeCounter.sv
src/stepSequencer.sv
src/regStrobeDecoder.sv
src/encoderController.sv
sim/controllerMonitor.sv
sim/tbEncoderController.sv

// ==== sim/controllerMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module controllerMonitor #(
	parameter int frameSize = 80,
	parameter int subframeSize = 40,
	parameter int framesPerAnalysis = 2
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire logic frameDone,
	input wire logic divErr,
	input wire encoderSeqPkg::unitVec unitDone,
	input wire encoderSeqPkg::unitVec unitStart,
	input wire encoderSeqPkg::stepSel mathMuxSel,
	input wire encoderSeqPkg::regStrobes regLoad,
	input wire encoderSeqPkg::regStrobes regClear,
	input wire logic done,
	output int errorCount,
	output int passCount
);

	import encoderSeqPkg::*;

	localparam int numSubframes = frameSize / subframeSize;

	typedef enum int {
		mIdle,
		mWaitAnalysis,
		mRun
	} modelState;

	modelState mState;
	logic gateOn;
	int frameCount;                            // Frames seen in the current group
	logic startDue;                            // A start pulse belongs in this cycle
	logic awaiting;
	logic doneDue;
	unitId curUnit;                            // Unit in flight
	int stepQ[$];
	unitId unitQ[$];

	// Struct order follows the enum, autocorr in the MSB
	function automatic unitVec oneHotOf(input unitId unit);
		return unitVec'(23'h40_0000 >> int'(unit));
	endfunction

	function automatic regStrobes loadRule(input unitId unit);
		// tOp t0 t0Frac t0Bounds _ index gainPit gainCode sharp _ iSubfr iGamma aqAddr
		case (unit)
			pitchOl: return 11'b1001_0000_011;
			pitchFr3: return 11'b0110_0000_000;
			encLag3: return 11'b0001_1000_000;
			gPitch: return 11'b0000_0100_000;
			acelpCodebook: return 11'b0000_1000_000;
			quaGain: return 11'b0000_0111_000;
			updateExcErr: return 11'b0000_0000_101;
			default: return '0;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t: %s expected %0h, got %0h",
				$time, name, expected, actual);
			errorCount++;
		end
	endtask

	// Frame steps, then every subframe with parity pitch in the first one only
	task automatic buildPass;
		stepQ.delete();
		unitQ.delete();
		for (int i = 0; i < numFrameSteps; i++)
		begin
			stepQ.push_back(i);
			unitQ.push_back(frameSteps[i]);
		end
		for (int s = 0; s < numSubframes; s++)
			for (int j = 0; j < numSubframeSteps; j++)
				if (subframeSteps[j] != parityPitch || s == 0)
				begin
					stepQ.push_back(numFrameSteps + j);
					unitQ.push_back(subframeSteps[j]);
				end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cycle model, sampled at the rising edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin : watch
		modelState cur;
		logic hit;
		logic ready;
		regStrobes expClear;
		regStrobes expLoad;
		unitVec expStart;

		if (reset)
		begin
			mState = mIdle;
			gateOn = 1'b0;
			frameCount = 0;
			startDue = 1'b0;
			awaiting = 1'b0;
			doneDue = 1'b0;
			curUnit = autocorr;
			stepQ.delete();
			unitQ.delete();
			errorCount = 0;
			passCount = 0;
		end
		else
		begin
			cur = mState;
			expClear = (cur == mIdle) ? '1 : '0;
			checkValue("regClear", 32'(expClear), 32'(regClear));

			hit = awaiting && ((unitDone & oneHotOf(curUnit)) != '0);
			expLoad = hit ? loadRule(curUnit) : '0;
			checkValue("regLoad", 32'(expLoad), 32'(regLoad));

			expStart = startDue ? oneHotOf(unitQ[0]) : '0;
			checkValue("unitStart", 32'(expStart), 32'(unitStart));
			if (startDue)
				checkValue("mathMuxSel", 32'(stepQ[0]), 32'(mathMuxSel));
			checkValue("done", 32'(doneDue), 32'(done));

			if (doneDue)
			begin
				doneDue = 1'b0;
				mState = mIdle;
				passCount++;
			end
			if (startDue)
			begin
				curUnit = unitQ.pop_front();
				void'(stepQ.pop_front());
				startDue = 1'b0;
				awaiting = 1'b1;
			end
			else if (hit)
			begin
				awaiting = 1'b0;
				if (unitQ.size() > 0)
					startDue = 1'b1;           // Next start one cycle later
				else
					doneDue = 1'b1;
			end

			ready = gateOn && frameDone && (frameCount == framesPerAnalysis - 1);
			if (gateOn && frameDone)
				frameCount = ready ? 0 : frameCount + 1;
			if (!gateOn && start)
				gateOn = 1'b1;

			if (cur == mIdle && start)
				mState = mWaitAnalysis;
			if (cur == mWaitAnalysis && ready)
			begin
				buildPass();
				startDue = 1'b1;
				mState = mRun;
			end

			if (divErr)
			begin
				mState = mIdle;                // Pass dropped
				startDue = 1'b0;
				awaiting = 1'b0;
				doneDue = 1'b0;
				stepQ.delete();
				unitQ.delete();
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/tbEncoderController.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbEncoderController;

	import encoderSeqPkg::*;

	localparam int frameSize = 80;
	localparam int subframeSize = 40;
	localparam int framesPerAnalysis = 2;
	localparam int numTests = 6;
	localparam int waitLimit = 2000;           // Cycles per wait

	logic clock;
	logic reset;
	logic start;
	logic frameDone;
	logic divErr;
	unitVec unitDone;
	unitVec unitStart;
	stepSel mathMuxSel;
	regStrobes regLoad;
	regStrobes regClear;
	logic done;

	int errorCount;
	int passCount;
	int startCount = 0;
	int tbErrors = 0;
	logic hung = 1'b0;

	////////////////////////////////////////////////////////////////////////////
	// Test table with divErr after that many starts (0 for none), full passes and done pulses
	////////////////////////////////////////////////////////////////////////////

	string testName [numTests] = '{"idle frames", "single pass", "back to back",
		"abort at first unit", "abort in subframe", "abort late"};
	int abortAfter [numTests] = '{0, 0, 0, 1, 30, 50};
	int fullPasses [numTests] = '{0, 1, 2, 1, 1, 2};
	int expDone [numTests] = '{0, 1, 2, 1, 1, 2};

	encoderController #(
		.frameSize(frameSize),
		.subframeSize(subframeSize),
		.framesPerAnalysis(framesPerAnalysis)
	) u_encoderController (
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.divErr(divErr),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.regLoad(regLoad),
		.regClear(regClear),
		.done(done)
	);

	controllerMonitor #(
		.frameSize(frameSize),
		.subframeSize(subframeSize),
		.framesPerAnalysis(framesPerAnalysis)
	) u_controllerMonitor (
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.divErr(divErr),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.regLoad(regLoad),
		.regClear(regClear),
		.done(done),
		.errorCount(errorCount),
		.passCount(passCount)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#10 clock = ~clock;
	end

	// Unit model answering each start after 1 to 6 cycles
	initial
	begin : responder
		unitVec pending;
		int delay;
		forever
		begin
			@(posedge clock);
			if (!reset && unitStart != '0)
			begin
				pending = unitStart;
				startCount++;
				delay = 1 + int'($urandom % 6);
				repeat (delay - 1) @(posedge clock);
				@(negedge clock);
				unitDone = pending;
				@(negedge clock);
				unitDone = '0;
			end
		end
	end

	task automatic sendFrames;
		repeat (framesPerAnalysis)
		begin
			repeat (3) @(negedge clock);
			frameDone = 1'b1;
			@(negedge clock);
			frameDone = 1'b0;
		end
	endtask

	task automatic openPass;
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		sendFrames();
	endtask

	task automatic waitForStarts(input int target);
		int cycles;
		cycles = 0;
		while (startCount < target && cycles < waitLimit)
		begin
			@(negedge clock);
			cycles++;
		end
		if (startCount < target)
		begin
			$display("Timeout: unit start pulse %0d never came", target);
			hung = 1'b1;
		end
	endtask

	task automatic waitForPasses(input int target);
		int cycles;
		cycles = 0;
		while (passCount < target && cycles < waitLimit)
		begin
			@(negedge clock);
			cycles++;
		end
		if (passCount < target)
		begin
			$display("Timeout: pass %0d never finished", target);
			hung = 1'b1;
		end
	endtask

	task automatic runTest(input int abortAt, input int passes);
		int target;
		if (abortAt == 0 && passes == 0)
		begin
			sendFrames();                      // Gate still off on the first row
			repeat (20) @(negedge clock);
		end
		if (abortAt > 0)
		begin
			target = startCount + abortAt;
			openPass();
			waitForStarts(target);
			if (hung)
				return;
			divErr = 1'b1;
			@(negedge clock);
			divErr = 1'b0;
			repeat (10) @(negedge clock);      // Late done pulse drains
		end
		for (int p = 0; p < passes; p++)
		begin
			target = passCount + 1;
			openPass();
			waitForPasses(target);
			if (hung)
				return;
			repeat (4) @(negedge clock);
		end
	endtask

	initial
	begin : main
		int errBefore;
		int passBefore;
		int testErrors;
		int testsRun;

		reset = 1'b1;
		start = 1'b0;
		frameDone = 1'b0;
		divErr = 1'b0;
		unitDone = '0;
		testsRun = 0;
		void'($urandom(32'h35e5_230b));
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (4) @(negedge clock);

		for (int t = 0; t < numTests && !hung; t++)
		begin
			errBefore = errorCount + tbErrors;
			passBefore = passCount;
			runTest(abortAfter[t], fullPasses[t]);
			if (!hung && passCount - passBefore != expDone[t])
			begin
				$display("CHECK FAILED at %0t: done pulses in %s expected %0d, got %0d",
					$time, testName[t], expDone[t], passCount - passBefore);
				tbErrors++;
			end
			testErrors = errorCount + tbErrors - errBefore;
			$display("test %0d %s: %s, %0d errors", t, testName[t],
				(testErrors == 0 && !hung) ? "ok" : "bad", testErrors);
			testsRun++;
		end

		$display("%0d of %0d tests run, %0d errors, %0d timeouts",
			testsRun, numTests, errorCount + tbErrors, hung ? 1 : 0);
		if (errorCount + tbErrors == 0 && !hung)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/encoderController.sv ====
`timescale 1ns/1ps
`default_nettype none

module encoderController #(
	parameter int frameSize = 80,
	parameter int subframeSize = 40,
	parameter int framesPerAnalysis = 2
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire logic frameDone,
	input wire logic divErr,
	input wire encoderSeqPkg::unitVec unitDone,
	output encoderSeqPkg::unitVec unitStart,
	output encoderSeqPkg::stepSel mathMuxSel,
	output encoderSeqPkg::regStrobes regLoad,
	output encoderSeqPkg::regStrobes regClear,
	output logic done
);

	import encoderSeqPkg::*;

	logic analysisReady;
	logic firstSubframe;
	logic lastSubframe;
	logic advance;
	logic restart;
	logic idle;
	doneEvent doneEvt;                         // Completed unit, same cycle as its done

	////////////////////////////////////////////////////////////////////////////
	// Frame grouping and subframe tracking
	////////////////////////////////////////////////////////////////////////////

	frameGate #(
		.framesPerAnalysis(framesPerAnalysis)
	) u_frameGate (
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.analysisReady(analysisReady)
	);

	subframeCounter #(
		.frameSize(frameSize),
		.subframeSize(subframeSize)
	) u_subframeCounter (
		.clock(clock),
		.reset(reset),
		.restart(restart),
		.advance(advance),
		.firstSubframe(firstSubframe),
		.lastSubframe(lastSubframe)
	);

	////////////////////////////////////////////////////////////////////////////
	// Unit sequencing and register strobes
	////////////////////////////////////////////////////////////////////////////

	stepSequencer u_stepSequencer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.analysisReady(analysisReady),
		.unitDone(unitDone),
		.firstSubframe(firstSubframe),
		.lastSubframe(lastSubframe),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.doneEvt(doneEvt),
		.idle(idle),
		.advance(advance),
		.restart(restart),
		.done(done)
	);

	regStrobeDecoder u_regStrobeDecoder (
		.doneEvt(doneEvt),
		.idle(idle),
		.regLoad(regLoad),
		.regClear(regClear)
	);

endmodule

`default_nettype wire

// ==== src/encoderSeqPkg.sv ====
`default_nettype none

package encoderSeqPkg;

	////////////////////////////////////////////////////////////////////////////
	// Encoder units and their start/done vectors
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		autocorr, lagWindow, levinson, azToLsp, quaLsp, intLpc, intQlpc, percVar,
		weightAz, residu, synFilt, pitchOl,
		pitchFr3, encLag3, parityPitch, predLt3, convolve, gPitch, testErr,
		acelpCodebook, corrXy2, quaGain, updateExcErr
	} unitId;

	// One bit per unit, autocorr in the MSB
	typedef struct packed {
		logic autocorr, lagWindow, levinson, azToLsp, quaLsp, intLpc, intQlpc, percVar;
		logic weightAz, residu, synFilt, pitchOl;
		logic pitchFr3, encLag3, parityPitch, predLt3, convolve, gPitch, testErr;
		logic acelpCodebook, corrXy2, quaGain, updateExcErr;
	} unitVec;

	localparam int numUnits = $bits(unitVec);

	typedef enum logic [2:0] {
		idle,
		waitAnalysis,
		issue,                                 // Start pulse for the current step
		waitDone,
		loopCheck,                             // Start of the next subframe
		finish
	} seqState;

	// Load/clear strobes of the shared encoder registers
	typedef struct packed {
		logic tOp, t0, t0Frac, t0Bounds, index, gainPit, gainCode, sharp;
		logic iSubfr, iGamma, aqAddr;
	} regStrobes;

	typedef struct packed {
		logic valid;
		unitId id;                             // Unit that just completed
	} doneEvent;

	typedef logic [5:0] stepSel;

	////////////////////////////////////////////////////////////////////////////
	// Step tables
	////////////////////////////////////////////////////////////////////////////

	localparam int numFrameSteps = 17;
	localparam int numSubframeSteps = 19;

	localparam unitId frameSteps [numFrameSteps] = '{
		autocorr, lagWindow, levinson, azToLsp, quaLsp, intLpc, intQlpc, percVar,
		weightAz, weightAz, residu, synFilt,
		weightAz, weightAz, residu, synFilt,
		pitchOl
	};

	localparam unitId subframeSteps [numSubframeSteps] = '{
		weightAz, weightAz, synFilt, synFilt, residu, synFilt, residu, synFilt,
		pitchFr3, encLag3, parityPitch, predLt3, convolve, gPitch, testErr, acelpCodebook,
		corrXy2, quaGain, updateExcErr
	};

	// Unit run at a given step index, subframe steps follow the frame steps
	function automatic unitId stepUnit(input stepSel step);
		stepSel subIdx;
		subIdx = step - stepSel'(numFrameSteps);
		if (step < stepSel'(numFrameSteps))
			return frameSteps[step[4:0]];
		return subframeSteps[subIdx[4:0]];
	endfunction

	function automatic unitVec unitMask(input unitId unit);
		logic [numUnits-1:0] bits;
		bits = '0;
		bits[numUnits - 1 - int'(unit)] = 1'b1;
		return unitVec'(bits);
	endfunction

endpackage

`default_nettype wire

// ==== src/frameGate.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameGate #(
	parameter int framesPerAnalysis = 2
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire logic frameDone,
	output logic analysisReady
);

	localparam int countW = $clog2(framesPerAnalysis + 1);
	localparam logic [countW-1:0] lastCount = countW'(framesPerAnalysis - 1);

	typedef enum logic {
		gateOff,
		gateRunning
	} gateState;

	gateState state;
	logic [countW-1:0] frameCount;             // Frames seen in current group

	// Group complete on this frame
	assign analysisReady = (state == gateRunning) && frameDone && (frameCount == lastCount);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= gateOff;
			frameCount <= '0;
		end
		else
		begin
			if (state == gateOff && start)
				state <= gateRunning;          // Runs until reset
			if (state == gateRunning && frameDone)
			begin
				if (frameCount == lastCount)
					frameCount <= '0;
				else
					frameCount <= frameCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/regStrobeDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module regStrobeDecoder (
	input wire encoderSeqPkg::doneEvent doneEvt,
	input wire logic idle,
	output encoderSeqPkg::regStrobes regLoad,
	output encoderSeqPkg::regStrobes regClear
);

	import encoderSeqPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Register loads on unit completion
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		regLoad = '0;
		if (doneEvt.valid)
		begin
			case (doneEvt.id)
				pitchOl:
				begin
					regLoad.tOp = 1'b1;        // Open-loop lag
					regLoad.t0Bounds = 1'b1;
					regLoad.aqAddr = 1'b1;
					regLoad.iGamma = 1'b1;
				end

				pitchFr3:
				begin
					regLoad.t0 = 1'b1;
					regLoad.t0Frac = 1'b1;
				end

				encLag3:
				begin
					regLoad.index = 1'b1;      // Lag code
					regLoad.t0Bounds = 1'b1;   // Search range for next subframe
				end

				gPitch:
					regLoad.gainPit = 1'b1;

				acelpCodebook:
					regLoad.index = 1'b1;      // Fixed codebook index

				// Quantized gains plus pitch sharpening
				quaGain:
				begin
					regLoad.gainPit = 1'b1;
					regLoad.gainCode = 1'b1;
					regLoad.sharp = 1'b1;
				end

				updateExcErr:
				begin
					regLoad.iSubfr = 1'b1;
					regLoad.aqAddr = 1'b1;     // Next subframe's coefficients
				end

				default:
					regLoad = '0;
			endcase
		end
	end

	// Every shared register held clear while idle
	assign regClear = idle ? '1 : '0;

endmodule

`default_nettype wire

// ==== src/stepSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepSequencer (
	input wire logic clock,
	input wire logic reset,
	input wire logic start,
	input wire logic divErr,
	input wire logic analysisReady,
	input wire encoderSeqPkg::unitVec unitDone,
	input wire logic firstSubframe,
	input wire logic lastSubframe,
	output encoderSeqPkg::unitVec unitStart,
	output encoderSeqPkg::stepSel mathMuxSel,
	output encoderSeqPkg::doneEvent doneEvt,
	output logic idle,
	output logic advance,
	output logic restart,
	output logic done
);

	import encoderSeqPkg::*;

	localparam stepSel firstSubStep = stepSel'(numFrameSteps);
	localparam stepSel lastStep = stepSel'(numFrameSteps + numSubframeSteps - 1);

	seqState state;
	seqState nextState;
	stepSel step;                              // Index of the current step
	stepSel nextStep;
	stepSel stepInc;
	unitId curUnit;
	logic doneHit;

	////////////////////////////////////////////////////////////////////////////
	// Step lookup and done matching
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		curUnit = stepUnit(step);
		doneHit = |(unitDone & unitMask(curUnit));   // Other units' done bits ignored

		// Parity pitch only belongs to the first subframe
		stepInc = step + 6'd1;
		if (stepUnit(stepInc) == parityPitch && !firstSubframe)
			stepInc = step + 6'd2;
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencing FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextStep = step;
		unitStart = '0;
		doneEvt = '0;
		advance = 1'b0;
		done = 1'b0;

		case (state)
			encoderSeqPkg::idle:
			begin
				if (start)
					nextState = waitAnalysis;
			end

			waitAnalysis:
			begin
				if (analysisReady)
				begin
					nextState = issue;
					nextStep = '0;             // Pass opens at autocorr
				end
			end

			issue:
			begin
				unitStart = unitMask(curUnit);
				nextState = waitDone;
			end

			waitDone:
			begin
				if (doneHit)
				begin
					doneEvt.valid = 1'b1;
					doneEvt.id = curUnit;
					if (step == lastStep)
					begin
						nextStep = firstSubStep;
						nextState = lastSubframe ? finish : loopCheck;
					end
					else
					begin
						nextStep = stepInc;
						nextState = issue;
					end
				end
			end

			// First step of the next subframe goes out together with the offset step
			loopCheck:
			begin
				unitStart = unitMask(curUnit);
				advance = 1'b1;
				nextState = waitDone;
			end

			finish:
			begin
				done = 1'b1;
				nextState = encoderSeqPkg::idle;
			end

			default:
				nextState = encoderSeqPkg::idle;
		endcase

		if (divErr)
			nextState = encoderSeqPkg::idle;   // Abort the pass
	end

	assign idle = (state == encoderSeqPkg::idle);
	assign restart = (state == encoderSeqPkg::idle);   // Back to subframe zero
	assign mathMuxSel = step;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= encoderSeqPkg::idle;
			step <= '0;
		end
		else
		begin
			state <= nextState;
			step <= nextStep;
		end
	end

endmodule

`default_nettype wire

// ==== src/subframeCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module subframeCounter #(
	parameter int frameSize = 80,
	parameter int subframeSize = 40
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic restart,
	input wire logic advance,
	output logic firstSubframe,
	output logic lastSubframe
);

	// Room for the offset one step past the frame end
	localparam int offsetW = $clog2(frameSize + subframeSize + 1);

	logic [offsetW-1:0] offset;                // Sample offset of current subframe
	logic [offsetW-1:0] nextOffset;

	assign nextOffset = offset + offsetW'(subframeSize);

	assign firstSubframe = (offset == '0);
	assign lastSubframe = (nextOffset >= offsetW'(frameSize));

	always_ff @(posedge clock)
	begin
		if (reset)
			offset <= '0;
		else if (restart)
			offset <= '0;
		else if (advance)
			offset <= nextOffset;
	end

endmodule

`default_nettype wire
